// File: Bender.yml
package:
  name: streaming_cntl

sources:
  - common/so_cntl_pkg.sv
  - design/op_decode.sv
  - design/mem_session.sv
  - lane/lane_sequencer.sv
  - design/streaming_cntl.sv
  - target: test
    files:
      - testbench/stream_responder.sv
      - testbench/tb_streaming_cntl.sv

// File: common/so_cntl_pkg.sv
// streaming-op controller package with operation word fields, widths and FSM states
`default_nettype none

package so_cntl_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------
  typedef logic [31:0] op_word_t;
  typedef logic [3:0]  pe_id_t;
  // 0, 1 or 2 streams
  typedef logic [1:0]  stream_cnt_t;
  typedef logic [1:0]  stream_sel_t;
  // bit 0 is stream 0
  typedef logic [1:0]  stream_pair_t;

  // --------------------------------------------------------------------------
  // operation word layout
  // --------------------------------------------------------------------------
  localparam int unsigned OP_ENABLE_BIT  = 0;
  localparam int unsigned OP_S0_SRC_LSB  = 4;
  localparam int unsigned OP_S1_SRC_LSB  = 6;
  localparam int unsigned OP_S0_DEST_LSB = 8;
  localparam int unsigned OP_S1_DEST_LSB = 10;
  localparam int unsigned OP_NUM_SRC_LSB = 12;

  // from memory as a source, to memory as a destination
  localparam stream_sel_t SEL_MEMORY = 2'd1;

  // --------------------------------------------------------------------------
  // state machines
  // --------------------------------------------------------------------------
  typedef enum logic [2:0] {
    SES_WAIT,
    SES_MEM_REQ,
    SES_MEM_GRANTED,
    SES_OP_RUN,
    SES_RELEASE,
    SES_COMPLETE
  } session_state_e;

  typedef enum logic [2:0] {
    LN_WAIT,
    LN_DMA_WRITE,
    LN_ENABLE_STOP,
    LN_DMA_READ,
    LN_OP_RUN,
    LN_WAIT_SYNC,
    LN_COMPLETE
  } lane_state_e;

endpackage

`default_nettype wire

// File: compile.f
common/so_cntl_pkg.sv
design/op_decode.sv
design/mem_session.sv
lane/lane_sequencer.sv
design/streaming_cntl.sv
testbench/stream_responder.sv
testbench/tb_streaming_cntl.sv

// File: design/mem_session.sv
// memory session controller that acquires PE memory, starts the lanes and gathers completion
`timescale 1ns/1ps
`default_nettype none

module mem_session #(
  parameter int unsigned NUM_LANES = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 enable,
  input  logic                 mem_granted,
  input  logic [NUM_LANES-1:0] lane_active,
  input  logic [NUM_LANES-1:0] lane_drained,
  input  logic [NUM_LANES-1:0] lane_done,
  output logic                 mem_request,
  output logic                 mem_released,
  output logic                 lane_go,
  output logic                 ready,
  output logic                 complete,
  output logic                 this_synchronized
);

  import so_cntl_pkg::*;

  session_state_e state;
  session_state_e state_next;
  logic           lanes_done;
  logic           lanes_drained;
  logic           mem_request_next;
  logic           mem_released_next;

  // inactive lanes count as finished, empty mask is done at once
  assign lanes_done    = &(lane_done | ~lane_active);
  assign lanes_drained = &(lane_drained | ~lane_active);

  // only meaningful while the lanes hold memory
  assign this_synchronized = lane_go & lanes_drained;

  // --------------------------------------------------------------------------
  // session FSM
  // --------------------------------------------------------------------------
  always_comb
  begin
    case (state)
      SES_WAIT:        state_next = enable ? SES_MEM_REQ : SES_WAIT;
      SES_MEM_REQ:     state_next = !enable ? SES_RELEASE :
                                    mem_granted ? SES_MEM_GRANTED : SES_MEM_REQ;
      SES_MEM_GRANTED: state_next = !enable ? SES_RELEASE : SES_OP_RUN;
      SES_OP_RUN:      state_next = (!enable || lanes_done) ? SES_RELEASE : SES_OP_RUN;
      // hold until the controller drops granted
      SES_RELEASE:     state_next = mem_granted ? SES_RELEASE : SES_COMPLETE;
      SES_COMPLETE:    state_next = enable ? SES_COMPLETE : SES_WAIT;
      default:         state_next = SES_WAIT;
    endcase
  end

  // request held from enable up to the end of the run
  assign mem_request_next = ((state == SES_WAIT) && enable) ||
                            (state == SES_MEM_REQ) ||
                            (state == SES_MEM_GRANTED) ||
                            (state == SES_OP_RUN);

  // released drops only once memory is really ours
  assign mem_released_next = (state == SES_WAIT) ||
                             (state == SES_MEM_REQ) ||
                             (state == SES_RELEASE) ||
                             (state == SES_COMPLETE);

  // --------------------------------------------------------------------------
  // registered outputs
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= SES_WAIT;
      mem_request  <= 1'b0;
      mem_released <= 1'b1;
      lane_go      <= 1'b0;
      ready        <= 1'b0;
      complete     <= 1'b0;
    end
    else
    begin
      state        <= state_next;
      mem_request  <= mem_request_next;
      mem_released <= mem_released_next;
      // ready, lane_go and complete all clear back in wait
      if (state == SES_WAIT)
      begin
        lane_go  <= 1'b0;
        ready    <= 1'b0;
        complete <= 1'b0;
      end
      else
      begin
        if (state == SES_OP_RUN)
        begin
          lane_go <= 1'b1;
          ready   <= 1'b1;
        end
        if (state == SES_COMPLETE)
        begin
          complete <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/op_decode.sv
// operation decoder giving the enable bit and the source and memory stream counts
`timescale 1ns/1ps
`default_nettype none

module op_decode (
  input  so_cntl_pkg::op_word_t    op_word,
  output logic                     enable,
  output so_cntl_pkg::stream_cnt_t num_src,
  output so_cntl_pkg::stream_cnt_t streams_from_mem,
  output so_cntl_pkg::stream_cnt_t streams_to_mem
);

  import so_cntl_pkg::*;

  stream_sel_t s0_src;
  stream_sel_t s1_src;
  stream_sel_t s0_dest;
  stream_sel_t s1_dest;
  // per stream memory hits, stream 0 in bit 0
  stream_pair_t src_hit;
  stream_pair_t dest_hit;

  // field extraction
  assign enable  = op_word[OP_ENABLE_BIT];
  assign num_src = op_word[OP_NUM_SRC_LSB +: $bits(stream_cnt_t)];
  assign s0_src  = op_word[OP_S0_SRC_LSB +: $bits(stream_sel_t)];
  assign s1_src  = op_word[OP_S1_SRC_LSB +: $bits(stream_sel_t)];
  assign s0_dest = op_word[OP_S0_DEST_LSB +: $bits(stream_sel_t)];
  assign s1_dest = op_word[OP_S1_DEST_LSB +: $bits(stream_sel_t)];

  assign src_hit  = {s1_src == SEL_MEMORY, s0_src == SEL_MEMORY};
  assign dest_hit = {s1_dest == SEL_MEMORY, s0_dest == SEL_MEMORY};

  // --------------------------------------------------------------------------
  // memory stream counts
  // --------------------------------------------------------------------------
  always_comb
  begin
    case (src_hit)
      2'b11:   streams_from_mem = 2'd2;
      2'b01,
      2'b10:   streams_from_mem = 2'd1;
      default: streams_from_mem = 2'd0;
    endcase
  end

  // same rule for the destinations
  always_comb
  begin
    case (dest_hit)
      2'b11:   streams_to_mem = 2'd2;
      2'b01,
      2'b10:   streams_to_mem = 2'd1;
      default: streams_to_mem = 2'd0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/streaming_cntl.sv
// streaming-op controller top with decoder, memory session and per-lane sequencers
`timescale 1ns/1ps
`default_nettype none

module streaming_cntl #(
  parameter int unsigned         NUM_LANES = 4,
  parameter so_cntl_pkg::pe_id_t PE_ID     = 4'd5
) (
  input  logic                                              clk,
  input  logic                                              rst_n,
  // core side
  input  so_cntl_pkg::op_word_t                             op_word,
  input  logic [NUM_LANES-1:0]                              lane_active,
  output logic                                              ready,
  output logic                                              complete,
  input  logic                                              all_synchronized,
  output logic                                              this_synchronized,
  // memory controller handshake
  output logic                                              mem_request,
  input  logic                                              mem_granted,
  output logic                                              mem_released,
  // unit controls, two bits per lane
  output logic [NUM_LANES*2-1:0]                            dma_write_en,
  output logic [NUM_LANES*2-1:0]                            stop_en,
  output logic [NUM_LANES*2-1:0]                            dma_read_en,
  input  logic [NUM_LANES*2-1:0]                            dma_write_done,
  input  logic [NUM_LANES*2-1:0]                            stop_ready,
  input  logic [NUM_LANES*2-1:0]                            stop_done,
  input  logic [NUM_LANES*2-1:0]                            dma_read_done,
  input  logic [NUM_LANES*2*$bits(so_cntl_pkg::pe_id_t)-1:0] read_pe_id
);

  import so_cntl_pkg::*;

  localparam int unsigned ID_W = $bits(pe_id_t);

  logic                 enable;
  stream_cnt_t          num_src;
  stream_cnt_t          streams_from_mem;
  stream_cnt_t          streams_to_mem;
  logic                 lane_go;
  logic [NUM_LANES-1:0] lane_drained;
  logic [NUM_LANES-1:0] lane_done;

  op_decode u_op_decode (
    .op_word          (op_word),
    .enable           (enable),
    .num_src          (num_src),
    .streams_from_mem (streams_from_mem),
    .streams_to_mem   (streams_to_mem)
  );

  mem_session #(
    .NUM_LANES (NUM_LANES)
  ) u_mem_session (
    .clk               (clk),
    .rst_n             (rst_n),
    .enable            (enable),
    .mem_granted       (mem_granted),
    .lane_active       (lane_active),
    .lane_drained      (lane_drained),
    .lane_done         (lane_done),
    .mem_request       (mem_request),
    .mem_released      (mem_released),
    .lane_go           (lane_go),
    .ready             (ready),
    .complete          (complete),
    .this_synchronized (this_synchronized)
  );

  // --------------------------------------------------------------------------
  // one sequencer per execution lane
  // --------------------------------------------------------------------------
  for (genvar gi = 0; gi < NUM_LANES; gi++)
  begin : g_lane
    lane_sequencer #(
      .PE_ID (PE_ID)
    ) u_lane_sequencer (
      .clk              (clk),
      .rst_n            (rst_n),
      .lane_go          (lane_go),
      .lane_enable      (lane_active[gi]),
      .all_synchronized (all_synchronized),
      .num_src          (num_src),
      .streams_from_mem (streams_from_mem),
      .streams_to_mem   (streams_to_mem),
      .read_pe_id       (read_pe_id[gi*2*ID_W +: 2*ID_W]),
      .dma_write_done   (dma_write_done[gi*2 +: 2]),
      .stop_ready       (stop_ready[gi*2 +: 2]),
      .stop_done        (stop_done[gi*2 +: 2]),
      .dma_read_done    (dma_read_done[gi*2 +: 2]),
      .dma_write_en     (dma_write_en[gi*2 +: 2]),
      .stop_en          (stop_en[gi*2 +: 2]),
      .dma_read_en      (dma_read_en[gi*2 +: 2]),
      .lane_drained     (lane_drained[gi]),
      .lane_done        (lane_done[gi])
    );
  end

endmodule

`default_nettype wire

// File: lane/lane_sequencer.sv
// per-lane stream sequencer driving the DMA write, streaming-op and DMA read enables
`timescale 1ns/1ps
`default_nettype none

module lane_sequencer #(
  parameter so_cntl_pkg::pe_id_t PE_ID = 4'd5
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           lane_go,
  input  logic                           lane_enable,
  input  logic                           all_synchronized,
  input  so_cntl_pkg::stream_cnt_t       num_src,
  input  so_cntl_pkg::stream_cnt_t       streams_from_mem,
  input  so_cntl_pkg::stream_cnt_t       streams_to_mem,
  input  so_cntl_pkg::pe_id_t      [1:0] read_pe_id,
  input  so_cntl_pkg::stream_pair_t      dma_write_done,
  input  so_cntl_pkg::stream_pair_t      stop_ready,
  input  so_cntl_pkg::stream_pair_t      stop_done,
  input  so_cntl_pkg::stream_pair_t      dma_read_done,
  output so_cntl_pkg::stream_pair_t      dma_write_en,
  output so_cntl_pkg::stream_pair_t      stop_en,
  output so_cntl_pkg::stream_pair_t      dma_read_en,
  output logic                           lane_drained,
  output logic                           lane_done
);

  import so_cntl_pkg::*;

  lane_state_e  state;
  lane_state_e  state_next;
  // units this operation will use
  stream_pair_t write_want;
  stream_pair_t stop_want;
  stream_pair_t read_want;
  stream_pair_t read_local;
  logic         stop_all_ready;
  logic         units_all_done;

  // stream 0 from a count of 1, stream 1 only from 2
  assign write_want = {streams_to_mem == 2'd2, streams_to_mem >= 2'd1};
  assign stop_want  = {num_src == 2'd2, num_src >= 2'd1};

  // reads only from this PE's own memory
  assign read_local = {read_pe_id[1] == PE_ID, read_pe_id[0] == PE_ID};
  assign read_want  = {streams_from_mem == 2'd2, streams_from_mem >= 2'd1} & read_local;

  // unused units count as finished
  assign stop_all_ready = &(stop_ready | ~stop_want);
  assign units_all_done = &(dma_write_done | ~write_want) &
                          &(stop_done | ~stop_want) &
                          &(dma_read_done | ~read_want);

  assign lane_drained = (state == LN_WAIT_SYNC) || (state == LN_COMPLETE);

  // --------------------------------------------------------------------------
  // stream FSM
  // --------------------------------------------------------------------------
  always_comb
  begin
    state_next = state;
    case (state)
      LN_WAIT:        state_next = (lane_go && lane_enable) ? LN_DMA_WRITE : LN_WAIT;
      LN_DMA_WRITE:   state_next = LN_ENABLE_STOP;
      LN_ENABLE_STOP: state_next = stop_all_ready ? LN_DMA_READ : LN_ENABLE_STOP;
      LN_DMA_READ:    state_next = LN_OP_RUN;
      LN_OP_RUN:      state_next = units_all_done ? LN_WAIT_SYNC : LN_OP_RUN;
      LN_WAIT_SYNC:   state_next = all_synchronized ? LN_COMPLETE : LN_WAIT_SYNC;
      LN_COMPLETE:    state_next = lane_go ? LN_COMPLETE : LN_WAIT;
      default:        state_next = LN_WAIT;
    endcase
    // session gave up memory mid sequence
    if (!lane_go && (state != LN_WAIT) && (state != LN_COMPLETE))
    begin
      state_next = LN_COMPLETE;
    end
  end

  // --------------------------------------------------------------------------
  // enable registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= LN_WAIT;
      dma_write_en <= '0;
      stop_en      <= '0;
      dma_read_en  <= '0;
      lane_done    <= 1'b0;
    end
    else
    begin
      state <= state_next;
      // write engines first so the sinks are ready
      if (state == LN_DMA_WRITE)
        dma_write_en <= dma_write_en | write_want;
      else if (state == LN_COMPLETE)
        dma_write_en <= '0;
      // streaming-op units stay on until back in wait
      if (state == LN_ENABLE_STOP)
        stop_en <= stop_en | stop_want;
      else if (state == LN_WAIT)
        stop_en <= '0;
      // read engines last, once the ops are ready
      if (state == LN_DMA_READ)
        dma_read_en <= dma_read_en | read_want;
      else if (state == LN_COMPLETE)
        dma_read_en <= '0;
      if (state == LN_COMPLETE)
        lane_done <= 1'b1;
      else if (state == LN_WAIT)
        lane_done <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: testbench/stream_responder.sv
// lane unit model answering DMA and streaming-op enables with ready and done
`timescale 1ns/1ps
`default_nettype none

module stream_responder (
  input  logic       clk,
  input  logic [2:0] delay,
  input  logic [1:0] write_en,
  input  logic [1:0] stop_en,
  input  logic [1:0] read_en,
  output logic [1:0] write_done,
  output logic [1:0] stop_ready,
  output logic [1:0] stop_done,
  output logic [1:0] read_done
);

  // cycles since each enable group came on
  int unsigned write_age = 0;
  int unsigned stop_age = 0;
  int unsigned read_age = 0;

  always @(posedge clk)
  begin
    #1;
    write_age = (write_en != 2'b00) ? write_age + 1 : 0;
    stop_age  = (stop_en != 2'b00) ? stop_age + 1 : 0;
    read_age  = (read_en != 2'b00) ? read_age + 1 : 0;
  end

  // held high until the enable drops
  assign write_done = write_en & {2{write_age > delay}};
  assign stop_ready = stop_en & {2{stop_age > delay}};
  // ops finish a few cycles after ready
  assign stop_done  = stop_en & {2{stop_age > delay + 3}};
  assign read_done  = read_en & {2{read_age > delay}};

endmodule

`default_nettype wire

// File: testbench/tb_streaming_cntl.sv
// testbench for the streaming-op controller with memory, sync and lane unit models
`timescale 1ns/1ps
`default_nettype none

module tb_streaming_cntl;

  import so_cntl_pkg::*;

  localparam int unsigned NUM_LANES = 4;
  localparam pe_id_t      PE_ID     = 4'd5;
  localparam int unsigned NUM_OPS   = 40;
  localparam int unsigned TIMEOUT   = NUM_OPS * 250;

  logic                         clk;
  logic                         rst_n;
  op_word_t                     op_word;
  logic [NUM_LANES-1:0]         lane_active;
  logic [NUM_LANES*2*4-1:0]     read_pe_id;
  logic                         mem_granted = 1'b0;
  logic                         all_synchronized = 1'b0;
  logic                         ready;
  logic                         complete;
  logic                         this_synchronized;
  logic                         mem_request;
  logic                         mem_released;
  logic [NUM_LANES*2-1:0]       dma_write_en;
  logic [NUM_LANES*2-1:0]       stop_en;
  logic [NUM_LANES*2-1:0]       dma_read_en;
  wire  [NUM_LANES*2-1:0]       dma_write_done;
  wire  [NUM_LANES*2-1:0]       stop_ready;
  wire  [NUM_LANES*2-1:0]       stop_done;
  wire  [NUM_LANES*2-1:0]       dma_read_done;

  // expected enables of the running operation
  logic [NUM_LANES*2-1:0]       exp_write;
  logic [NUM_LANES*2-1:0]       exp_stop;
  logic [NUM_LANES*2-1:0]       exp_read;
  logic [2:0]                   resp_delay [NUM_LANES];
  logic                         withdrawn;
  logic                         enable_bit;
  logic [NUM_LANES-1:0]         stop_ok;
  logic [NUM_LANES-1:0]         read_lanes;
  logic                         done_ok;
  logic [5:0]                   status_bits;
  int unsigned                  grant_delay;
  int unsigned                  sync_delay;
  int unsigned                  grant_wait = 0;
  int unsigned                  sync_wait = 0;
  int unsigned                  cycle_count = 0;
  logic [31:0]                  lcg_state = 32'h9d9ead27;

  streaming_cntl #(
    .NUM_LANES (NUM_LANES),
    .PE_ID     (PE_ID)
  ) UUT (
    .clk               (clk),
    .rst_n             (rst_n),
    .op_word           (op_word),
    .lane_active       (lane_active),
    .ready             (ready),
    .complete          (complete),
    .all_synchronized  (all_synchronized),
    .this_synchronized (this_synchronized),
    .mem_request       (mem_request),
    .mem_granted       (mem_granted),
    .mem_released      (mem_released),
    .dma_write_en      (dma_write_en),
    .stop_en           (stop_en),
    .dma_read_en       (dma_read_en),
    .dma_write_done    (dma_write_done),
    .stop_ready        (stop_ready),
    .stop_done         (stop_done),
    .dma_read_done     (dma_read_done),
    .read_pe_id        (read_pe_id)
  );

  for (genvar gl = 0; gl < NUM_LANES; gl++)
  begin : g_responder
    stream_responder u_stream_responder (
      .clk        (clk),
      .delay      (resp_delay[gl]),
      .write_en   (dma_write_en[gl*2 +: 2]),
      .stop_en    (stop_en[gl*2 +: 2]),
      .read_en    (dma_read_en[gl*2 +: 2]),
      .write_done (dma_write_done[gl*2 +: 2]),
      .stop_ready (stop_ready[gl*2 +: 2]),
      .stop_done  (stop_done[gl*2 +: 2]),
      .read_done  (dma_read_done[gl*2 +: 2])
    );
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // stream 0 from a count of 1, both from 2
  function automatic stream_pair_t stream_pattern(input int count);
    case (count)
      0:       return 2'b00;
      1:       return 2'b01;
      default: return 2'b11;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
    $display("sim failed");
    $fatal(1, "run stopped on a failed check");
  endtask

  // --------------------------------------------------------------------------
  // clock and models
  // --------------------------------------------------------------------------
  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // memory controller model granting after a delay and dropping once request falls
  always @(posedge clk)
  begin
    #1;
    if (!mem_request)
    begin
      mem_granted = 1'b0;
      grant_wait  = 0;
    end
    else if (grant_wait >= grant_delay)
      mem_granted = 1'b1;
    else
      grant_wait++;
  end

  // system sync model answering this PE's drained flag after a delay
  always @(posedge clk)
  begin
    #1;
    if (!this_synchronized)
    begin
      all_synchronized = 1'b0;
      sync_wait        = 0;
    end
    else if (sync_wait >= sync_delay)
      all_synchronized = 1'b1;
    else
      sync_wait++;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT)
    begin
      $display("timeout after %0d cycles, the DUT did not finish the operations", cycle_count);
      $display("sim failed");
      $fatal(1, "run stopped on timeout");
    end
  end

  assign enable_bit  = op_word[OP_ENABLE_BIT];
  assign status_bits = {mem_request, mem_released, ready, complete, this_synchronized,
                        |{dma_write_en, stop_en, dma_read_en}};
  assign done_ok     = &((dma_write_done | ~exp_write) & (stop_done | ~exp_stop) &
                         (dma_read_done | ~exp_read));

  // per lane view of ready and read enables
  always_comb
  begin
    for (int l = 0; l < NUM_LANES; l++)
    begin
      stop_ok[l]    = &(stop_ready[l*2 +: 2] | ~exp_stop[l*2 +: 2]);
      read_lanes[l] = |dma_read_en[l*2 +: 2];
    end
  end

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------
  assert property (@(posedge clk) !rst_n |-> status_bits == 6'b010000)
    else report_mismatch("reset_values", 6'b010000, $sampled(status_bits));
  assert property (@(posedge clk) disable iff (!rst_n) $rose(enable_bit) |=> mem_request)
    else report_mismatch("request_after_enable", 1'b1, 1'b0);
  assert property (@(posedge clk) disable iff (!rst_n)
                   $rose(mem_request) |-> $past(enable_bit) && !$past(enable_bit, 2))
    else report_mismatch("request_timing", 1'b1, 1'b0);
  // ready exactly 3 cycles after the grant
  assert property (@(posedge clk) disable iff (!rst_n)
                   $rose(ready) |-> $past(mem_granted, 3) && !$past(mem_granted, 4))
    else report_mismatch("ready_after_grant", 1'b1, 1'b0);
  // every grant is followed by ready
  assert property (@(posedge clk) disable iff (!rst_n)
                   $past(mem_granted, 3) && !$past(mem_granted, 4) |-> $rose(ready))
    else report_mismatch("ready_follows_grant", 1'b1, $sampled(ready));
  assert property (@(posedge clk) disable iff (!rst_n)
                   withdrawn |-> !ready && {dma_write_en, stop_en, dma_read_en} == '0)
    else report_mismatch("withdrawn_quiet", '0, $sampled({ready, dma_write_en, stop_en,
                                                          dma_read_en}));
  assert property (@(posedge clk) disable iff (!rst_n)
                   $past(ready, 2) && !$past(ready, 3) |->
                   dma_write_en == exp_write && stop_en == '0)
    else report_mismatch("write_phase", {exp_write, 8'h00}, $sampled({dma_write_en, stop_en}));
  // streaming ops one cycle behind the writes
  assert property (@(posedge clk) disable iff (!rst_n)
                   $past(ready, 3) && !$past(ready, 4) |-> stop_en == exp_stop)
    else report_mismatch("stop_phase", exp_stop, $sampled(stop_en));
  assert property (@(posedge clk) disable iff (!rst_n)
                   (read_lanes & ~$past(stop_ok, 2)) == '0)
    else report_mismatch("read_after_stop_ready", '0, $sampled(read_lanes));
  assert property (@(posedge clk) disable iff (!rst_n)
                   ((dma_write_en & ~exp_write) | (stop_en & ~exp_stop) |
                    (dma_read_en & ~exp_read)) == '0)
    else report_mismatch("no_extra_enables", {exp_write, exp_stop, exp_read},
                         $sampled({dma_write_en, stop_en, dma_read_en}));
  assert property (@(posedge clk) disable iff (!rst_n)
                   $rose(this_synchronized) |->
                   {dma_write_en, stop_en, dma_read_en} == {exp_write, exp_stop, exp_read})
    else report_mismatch("enables_at_sync", {exp_write, exp_stop, exp_read},
                         $sampled({dma_write_en, stop_en, dma_read_en}));
  assert property (@(posedge clk) disable iff (!rst_n)
                   $rose(this_synchronized) |-> $past(done_ok))
    else report_mismatch("sync_after_done", 1'b1, 1'b0);
  // request falls together with released rising
  assert property (@(posedge clk) disable iff (!rst_n)
                   $fell(mem_request) && !withdrawn |-> $past(all_synchronized, 2) &&
                   $rose(mem_released))
    else report_mismatch("release_after_sync", 1'b1, 1'b0);
  assert property (@(posedge clk) disable iff (!rst_n)
                   $rose(complete) |-> !$past(mem_granted, 2) && !mem_granted &&
                   mem_released && !mem_request)
    else report_mismatch("complete_after_release", 3'b010, $sampled({mem_granted,
                         mem_released, mem_request}));
  assert property (@(posedge clk) disable iff (!rst_n)
                   $past(!enable_bit && complete, 2) |-> !ready && !complete)
    else report_mismatch("enable_clears", 2'b00, $sampled({ready, complete}));

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  task automatic run_operation(input logic withdraw);
    logic [31:0]          r;
    stream_sel_t          src0;
    stream_sel_t          src1;
    stream_sel_t          dest0;
    stream_sel_t          dest1;
    stream_cnt_t          num_src;
    logic [NUM_LANES-1:0] mask;
    pe_id_t               id;
    int                   from_cnt;
    int                   to_cnt;
    stream_pair_t         local_ids;
    @(posedge clk);
    #1;
    r       = next_random();
    src0    = r[31:30];
    src1    = r[29:28];
    dest0   = r[27:26];
    dest1   = r[25:24];
    num_src = r[23:20] % 3;
    mask    = (r[19:16] == '0) ? 4'b1000 : r[19:16];
    // read ids either this PE or some other one
    for (int s = 0; s < NUM_LANES * 2; s++)
    begin
      r  = next_random();
      id = r[31] ? PE_ID : ((r[23:20] == PE_ID) ? 4'd0 : r[23:20]);
      read_pe_id[s*4 +: 4] = id;
    end
    r           = next_random();
    grant_delay = withdraw ? 1000 : r[31:29];
    sync_delay  = r[28:26];
    for (int l = 0; l < NUM_LANES; l++)
      resp_delay[l] = next_random() >> 29;
    from_cnt = int'(src0 == SEL_MEMORY) + int'(src1 == SEL_MEMORY);
    to_cnt   = int'(dest0 == SEL_MEMORY) + int'(dest1 == SEL_MEMORY);
    exp_write = '0;
    exp_stop  = '0;
    exp_read  = '0;
    for (int l = 0; l < NUM_LANES; l++)
    begin
      local_ids = {read_pe_id[l*8+4 +: 4] == PE_ID, read_pe_id[l*8 +: 4] == PE_ID};
      if (mask[l] && !withdraw)
      begin
        exp_write[l*2 +: 2] = stream_pattern(to_cnt);
        exp_stop[l*2 +: 2]  = stream_pattern(num_src);
        exp_read[l*2 +: 2]  = stream_pattern(from_cnt) & local_ids;
      end
    end
    withdrawn   = withdraw;
    lane_active = mask;
    op_word     = '0;
    op_word[OP_S0_SRC_LSB +: 2]  = src0;
    op_word[OP_S1_SRC_LSB +: 2]  = src1;
    op_word[OP_S0_DEST_LSB +: 2] = dest0;
    op_word[OP_S1_DEST_LSB +: 2] = dest1;
    op_word[OP_NUM_SRC_LSB +: 2] = num_src;
    op_word[OP_ENABLE_BIT]       = 1'b1;
    // pull the operation back while still waiting for memory
    if (withdraw)
    begin
      do
      begin
        @(posedge clk);
        #1;
      end
      while (!mem_request);
      @(posedge clk);
      #1;
      op_word[OP_ENABLE_BIT] = 1'b0;
    end
    do
    begin
      @(posedge clk);
      #1;
    end
    while (!complete);
    op_word[OP_ENABLE_BIT] = 1'b0;
    do
    begin
      @(posedge clk);
      #1;
    end
    while (complete || ready || ({dma_write_en, stop_en, dma_read_en} != '0));
    withdrawn = 1'b0;
  endtask

  initial
  begin
    rst_n       = 1'b1;
    op_word     = '0;
    lane_active = '0;
    read_pe_id  = '0;
    exp_write   = '0;
    exp_stop    = '0;
    exp_read    = '0;
    withdrawn   = 1'b0;
    grant_delay = 0;
    sync_delay  = 0;
    for (int l = 0; l < NUM_LANES; l++)
      resp_delay[l] = '0;
    #1;
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // every eighth operation is withdrawn before the grant
    for (int i = 0; i < NUM_OPS; i++)
      run_operation(i % 8 == 7);
    repeat (4) @(posedge clk);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire
